//--- Bender.yml
package:
  name: spi_multi

sources:
  - source/spi_multi_pkg.sv
  - source/byte_fifo.sv
  - source/spi_master_byte.sv
  - source/slave_scheduler.sv
  - source/if_spi_multi.sv
  - target: test
    files:
      - tb/spi_slave_model.sv
      - tb/tb_if_spi_multi.sv

//--- source/byte_fifo.sv
`default_nettype none

module byte_fifo (
  input  logic                        clk,
  input  logic                        n_rst,
  input  spi_multi_pkg::byte_t        data,
  input  logic                        wrreq,
  input  logic                        rdreq,
  output spi_multi_pkg::byte_t        q,
  output logic                        empty,
  output logic                        full,
  output spi_multi_pkg::fifo_count_t  count
);

  spi_multi_pkg::byte_t      mem [spi_multi_pkg::fifo_depth];
  spi_multi_pkg::fifo_ptr_t  wr_ptr;
  spi_multi_pkg::fifo_ptr_t  rd_ptr;
  logic                      do_push;
  logic                      do_pop;

  // Requests against a full or empty queue are dropped
  assign do_push = wrreq && !full;
  assign do_pop = rdreq && !empty;

  assign empty = (count == '0);
  assign full = (count == spi_multi_pkg::fifo_count_t'(spi_multi_pkg::fifo_depth));

  // Show-ahead read port
  assign q = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= data;
  end

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/if_spi_multi.sv
`default_nettype none

module if_spi_multi (
  input  logic                                               clk,
  input  logic                                               n_rst,

  output logic                                               sclk,
  output logic                                               mosi,
  input  logic                                               miso,
  output logic [spi_multi_pkg::n_slaves-1:0]                 n_cs_bus,

  input  spi_multi_pkg::byte_t                               m_din,
  input  logic [spi_multi_pkg::n_slaves-1:0]                 m_wrreq_bus,

  output spi_multi_pkg::byte_t [spi_multi_pkg::n_slaves-1:0] s_dout_bus,
  output spi_multi_pkg::len_t [spi_multi_pkg::n_slaves-1:0]  len_bus,
  output logic [spi_multi_pkg::n_slaves-1:0]                 have_msg_bus,
  input  logic [spi_multi_pkg::n_slaves-1:0]                 s_rdreq_bus
);

  spi_multi_pkg::byte_t [spi_multi_pkg::n_slaves-1:0]  tx_q_bus;
  logic [spi_multi_pkg::n_slaves-1:0]                  tx_empty_bus;
  logic [spi_multi_pkg::n_slaves-1:0]                  tx_pop_bus;
  logic [spi_multi_pkg::n_slaves-1:0]                  rx_full_bus;
  logic [spi_multi_pkg::n_slaves-1:0]                  rx_empty_bus;
  logic [spi_multi_pkg::n_slaves-1:0]                  rx_push_bus;
  spi_multi_pkg::fifo_count_t                          rx_count [spi_multi_pkg::n_slaves];

  spi_multi_pkg::byte_t  tx_data;
  spi_multi_pkg::byte_t  rx_data;
  logic                  tx_empty;
  logic                  rx_full;
  logic                  tx_pop;
  logic                  rx_push;
  logic                  cs_active;
  logic                  ready;

  slave_scheduler scheduler_i (
    .clk          (clk),
    .n_rst        (n_rst),
    .ready        (ready),
    .tx_empty_bus (tx_empty_bus),
    .tx_q_bus     (tx_q_bus),
    .rx_full_bus  (rx_full_bus),
    .tx_pop       (tx_pop),
    .rx_push      (rx_push),
    .cs_active    (cs_active),
    .tx_data      (tx_data),
    .tx_empty     (tx_empty),
    .rx_full      (rx_full),
    .tx_pop_bus   (tx_pop_bus),
    .rx_push_bus  (rx_push_bus),
    .n_cs_bus     (n_cs_bus)
  );

  spi_master_byte engine_i (
    .clk       (clk),
    .n_rst     (n_rst),
    .tx_data   (tx_data),
    .tx_empty  (tx_empty),
    .rx_full   (rx_full),
    .tx_pop    (tx_pop),
    .rx_data   (rx_data),
    .rx_push   (rx_push),
    .cs_active (cs_active),
    .ready     (ready),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso)
  );

  assign have_msg_bus = ~rx_empty_bus;

  // One transmit and one receive queue per slave
  for (genvar k = 0; k < spi_multi_pkg::n_slaves; k++)
  begin : g_slave
    byte_fifo tx_fifo_i (
      .clk   (clk),
      .n_rst (n_rst),
      .data  (m_din),
      .wrreq (m_wrreq_bus[k]),
      .rdreq (tx_pop_bus[k]),
      .q     (tx_q_bus[k]),
      .empty (tx_empty_bus[k]),
      .full  (),
      .count ()
    );

    byte_fifo rx_fifo_i (
      .clk   (clk),
      .n_rst (n_rst),
      .data  (rx_data),
      .wrreq (rx_push_bus[k]),
      .rdreq (s_rdreq_bus[k]),
      .q     (s_dout_bus[k]),
      .empty (rx_empty_bus[k]),
      .full  (rx_full_bus[k]),
      .count (rx_count[k])
    );

    assign len_bus[k] = spi_multi_pkg::len_t'(rx_count[k]);
  end

endmodule

`default_nettype wire

//--- source/slave_scheduler.sv
`default_nettype none

module slave_scheduler (
  input  logic                                               clk,
  input  logic                                               n_rst,
  input  logic                                               ready,
  input  logic [spi_multi_pkg::n_slaves-1:0]                 tx_empty_bus,
  input  spi_multi_pkg::byte_t [spi_multi_pkg::n_slaves-1:0] tx_q_bus,
  input  logic [spi_multi_pkg::n_slaves-1:0]                 rx_full_bus,
  input  logic                                               tx_pop,
  input  logic                                               rx_push,
  input  logic                                               cs_active,
  output spi_multi_pkg::byte_t                               tx_data,
  output logic                                               tx_empty,
  output logic                                               rx_full,
  output logic [spi_multi_pkg::n_slaves-1:0]                 tx_pop_bus,
  output logic [spi_multi_pkg::n_slaves-1:0]                 rx_push_bus,
  output logic [spi_multi_pkg::n_slaves-1:0]                 n_cs_bus
);

  spi_multi_pkg::slave_sel_t  select;
  logic                       advance;

  // Move on only when the engine is idle and this slave has nothing queued
  assign advance = ready && tx_empty;

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      select <= '0;
    else if (advance)
    begin
      if (select == spi_multi_pkg::slave_sel_t'(spi_multi_pkg::n_slaves - 1))
        select <= '0;
      else
        select <= select + 1'b1;
    end
  end

  assign tx_data = tx_q_bus[select];
  assign tx_empty = tx_empty_bus[select];
  assign rx_full = rx_full_bus[select];

  // Steer strobes and chip select back to the selected slave
  always_comb
  begin
    for (int k = 0; k < spi_multi_pkg::n_slaves; k++)
    begin
      tx_pop_bus[k] = tx_pop && (select == spi_multi_pkg::slave_sel_t'(k));
      rx_push_bus[k] = rx_push && (select == spi_multi_pkg::slave_sel_t'(k));
      n_cs_bus[k] = !(cs_active && (select == spi_multi_pkg::slave_sel_t'(k)));
    end
  end

endmodule

`default_nettype wire

//--- source/spi_master_byte.sv
`default_nettype none

module spi_master_byte (
  input  logic                  clk,
  input  logic                  n_rst,
  input  spi_multi_pkg::byte_t  tx_data,
  input  logic                  tx_empty,
  input  logic                  rx_full,
  output logic                  tx_pop,
  output spi_multi_pkg::byte_t  rx_data,
  output logic                  rx_push,
  output logic                  cs_active,
  output logic                  ready,
  output logic                  sclk,
  output logic                  mosi,
  input  logic                  miso
);

  spi_multi_pkg::spi_state_t  state;
  spi_multi_pkg::div_cnt_t    div_cnt;
  spi_multi_pkg::bit_cnt_t    bit_cnt;
  spi_multi_pkg::byte_t       shreg;
  logic                       can_start;
  logic                       in_shift;
  logic                       lead_edge;
  logic                       trail_edge;
  logic                       last_bit;

  // A byte may go only with data queued and room for the reply
  assign can_start = !tx_empty && !rx_full;

  assign in_shift = (state == spi_multi_pkg::shift);
  assign lead_edge = in_shift && (div_cnt == spi_multi_pkg::div_lead);
  assign trail_edge = in_shift && (div_cnt == spi_multi_pkg::div_last);
  assign last_bit = (bit_cnt == 3'd7);

  // Load pops only if the reply still fits, the preceding store may have filled rx
  assign tx_pop = (state == spi_multi_pkg::load) && can_start;
  assign rx_push = (state == spi_multi_pkg::store);
  assign rx_data = shreg;
  assign cs_active = (state != spi_multi_pkg::idle);
  assign ready = (state == spi_multi_pkg::idle);

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      state <= spi_multi_pkg::idle;
    end
    else
    begin
      case (state)
        spi_multi_pkg::idle:
        begin
          if (can_start)
            state <= spi_multi_pkg::load;
        end
        spi_multi_pkg::load:
        begin
          if (can_start)
            state <= spi_multi_pkg::shift;
          else
            state <= spi_multi_pkg::idle;
        end
        spi_multi_pkg::shift:
        begin
          if (trail_edge && last_bit)
            state <= spi_multi_pkg::store;
        end
        spi_multi_pkg::store:
        begin
          // Burst keeps chip select low
          if (can_start)
            state <= spi_multi_pkg::load;
          else
            state <= spi_multi_pkg::idle;
        end
        default:
        begin
          state <= spi_multi_pkg::idle;
        end
      endcase
    end
  end

  // Clock divider, bit counter and pin drivers
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk <= spi_multi_pkg::cpol;
      mosi <= 1'b0;
    end
    else if (tx_pop)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
      // MSB must be on the line before the first leading edge
      mosi <= tx_data[7];
    end
    else if (in_shift)
    begin
      if (trail_edge)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
      if (lead_edge)
        sclk <= ~spi_multi_pkg::cpol;
      if (trail_edge)
      begin
        sclk <= spi_multi_pkg::cpol;
        bit_cnt <= bit_cnt + 1'b1;
        if (!last_bit)
          mosi <= shreg[7];
      end
    end
  end

  // Outgoing bits leave at the top while miso fills from the bottom
  always_ff @(posedge clk)
  begin
    if (tx_pop)
      shreg <= tx_data;
    else if (lead_edge)
      shreg <= {shreg[6:0], miso};
  end

endmodule

`default_nettype wire

//--- source/spi_multi_pkg.sv
`default_nettype none

package spi_multi_pkg;

  localparam int n_slaves = 3;
  // Idle level of sclk
  localparam logic cpol = 1'b0;
  // clk cycles per sclk period, must be even
  localparam int clk_div = 8;
  localparam int fifo_depth_log2 = 6;
  localparam int fifo_depth = 1 << fifo_depth_log2;

  typedef logic [7:0] byte_t;
  typedef logic [$clog2(n_slaves)-1:0] slave_sel_t;
  typedef logic [fifo_depth_log2:0] fifo_count_t;
  typedef logic [fifo_depth_log2-1:0] fifo_ptr_t;
  typedef logic [7:0] len_t;
  typedef logic [$clog2(clk_div)-1:0] div_cnt_t;
  typedef logic [2:0] bit_cnt_t;

  // Divider positions of the leading and trailing sclk edges
  localparam div_cnt_t div_lead = div_cnt_t'(clk_div / 2 - 1);
  localparam div_cnt_t div_last = div_cnt_t'(clk_div - 1);

  typedef enum logic [1:0] {
    idle,
    load,
    shift,
    store
  } spi_state_t;

endpackage

`default_nettype wire

//--- spi_multi.f
source/spi_multi_pkg.sv
source/byte_fifo.sv
source/spi_master_byte.sv
source/slave_scheduler.sv
source/if_spi_multi.sv
tb/spi_slave_model.sv
tb/tb_if_spi_multi.sv

//--- tb/spi_slave_model.sv
`default_nettype none

module spi_slave_model #(
  parameter spi_multi_pkg::byte_t key = 8'h5a
) (
  input  wire logic n_cs,
  input  wire logic sclk,
  input  wire logic mosi,
  output wire logic miso
);

  spi_multi_pkg::byte_t  rx_log [$];
  spi_multi_pkg::byte_t  prev_rx = '0;
  spi_multi_pkg::byte_t  rx_shift = '0;
  spi_multi_pkg::byte_t  tx_shift = '0;
  int                    bit_cnt = 0;

  // Bus is released while deselected
  assign miso = n_cs ? 1'bz : tx_shift[7];

  // MSB of the reply is on miso as soon as chip select falls
  always @(negedge n_cs)
  begin
    tx_shift = prev_rx ^ key;
    bit_cnt = 0;
  end

  always @(posedge sclk)
  begin
    if (!n_cs)
    begin
      rx_shift = {rx_shift[6:0], mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
      begin
        rx_log.push_back(rx_shift);
        prev_rx = rx_shift;
        // Reply for the next byte of a burst
        tx_shift = rx_shift ^ key;
        bit_cnt = 0;
      end
    end
  end

  always @(negedge sclk)
  begin
    if (!n_cs && bit_cnt != 0)
      tx_shift = tx_shift << 1;
  end

endmodule

`default_nettype wire

//--- tb/tb_if_spi_multi.sv
`default_nettype none

module tb_if_spi_multi;

  localparam int n = spi_multi_pkg::n_slaves;
  localparam int byte_cycles = 2 + 8 * spi_multi_pkg::clk_div;
  localparam int random_ops = 40;
  localparam int total_bytes = 1 + 5 + 3 * n + 70 + random_ops;
  localparam int watchdog_time = total_bytes * byte_cycles * 4 * 3 + 40000;

  logic                                   clk;
  logic                                   n_rst;
  logic                                   sclk;
  logic                                   mosi;
  tri0                                    miso;
  logic [n-1:0]                           n_cs_bus;
  logic [n-1:0]                           cs_low;
  spi_multi_pkg::byte_t                   m_din;
  logic [n-1:0]                           m_wrreq_bus;
  spi_multi_pkg::byte_t [n-1:0]           s_dout_bus;
  spi_multi_pkg::len_t [n-1:0]            len_bus;
  logic [n-1:0]                           have_msg_bus;
  logic [n-1:0]                           s_rdreq_bus;

  spi_multi_pkg::byte_t  exp_sent [n][$];
  spi_multi_pkg::byte_t  exp_reply [n][$];
  spi_multi_pkg::byte_t  last_sent [n];
  int                    sent_total [n];
  int                    read_total [n];
  int                    cs_falls [n];
  int                    cs_order [$];
  logic [n-1:0]          cs_prev;
  int unsigned           lcg_state;

  if_spi_multi if_spi_multi_i (
    .clk          (clk),
    .n_rst        (n_rst),
    .sclk         (sclk),
    .mosi         (mosi),
    .miso         (miso),
    .n_cs_bus     (n_cs_bus),
    .m_din        (m_din),
    .m_wrreq_bus  (m_wrreq_bus),
    .s_dout_bus   (s_dout_bus),
    .len_bus      (len_bus),
    .have_msg_bus (have_msg_bus),
    .s_rdreq_bus  (s_rdreq_bus)
  );

  spi_slave_model #(.key(8'h5a)) slave0_i (
    .n_cs (n_cs_bus[0]),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  spi_slave_model #(.key(8'h5b)) slave1_i (
    .n_cs (n_cs_bus[1]),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  spi_slave_model #(.key(8'h5c)) slave2_i (
    .n_cs (n_cs_bus[2]),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  always #2 clk = ~clk;

  assign cs_low = ~n_cs_bus;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual)
    else abort_run($sformatf("[ERROR] %s expected %0h actual %0h", test, expected, actual));
  endtask

  function automatic spi_multi_pkg::byte_t rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return spi_multi_pkg::byte_t'(lcg_state >> 16);
  endfunction

  function automatic int log_size(input int s);
    case (s)
      0: return slave0_i.rx_log.size();
      1: return slave1_i.rx_log.size();
      default: return slave2_i.rx_log.size();
    endcase
  endfunction

  function automatic int log_entry(input int s, input int i);
    case (s)
      0: return slave0_i.rx_log[i];
      1: return slave1_i.rx_log[i];
      default: return slave2_i.rx_log[i];
    endcase
  endfunction

  // Slave k answers with its previous byte XOR (0x5a + k)
  task automatic push_byte(input int s, input spi_multi_pkg::byte_t d);
    m_din = d;
    m_wrreq_bus[s] = 1'b1;
    exp_sent[s].push_back(d);
    exp_reply[s].push_back(last_sent[s] ^ spi_multi_pkg::byte_t'(8'h5a + s));
    last_sent[s] = d;
    sent_total[s]++;
    @(negedge clk);
    m_wrreq_bus = '0;
  endtask

  task automatic read_byte(input string test, input int s);
    assert (have_msg_bus[s])
    else abort_run($sformatf("%s read slave %0d with no message present", test, s));
    check_value(test, exp_reply[s].pop_front(), s_dout_bus[s]);
    s_rdreq_bus[s] = 1'b1;
    read_total[s]++;
    @(negedge clk);
    s_rdreq_bus = '0;
  endtask

  // All written bytes shifted out and the bus released
  task automatic wait_done();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = (n_cs_bus != '1);
      for (int s = 0; s < n; s++)
        if (log_size(s) != sent_total[s])
          busy = 1'b1;
    end
  endtask

  task automatic check_logs(input string test);
    for (int s = 0; s < n; s++)
    begin
      check_value({test, " sent count"}, exp_sent[s].size(), log_size(s));
      for (int i = 0; i < exp_sent[s].size(); i++)
        check_value({test, " sent byte"}, exp_sent[s][i], log_entry(s, i));
    end
  endtask

  task automatic check_levels(input string test);
    for (int s = 0; s < n; s++)
    begin
      check_value({test, " len"}, sent_total[s] - read_total[s], len_bus[s]);
      check_value({test, " have_msg"}, sent_total[s] != read_total[s], have_msg_bus[s]);
    end
  endtask

  task automatic drain_all(input string test);
    for (int s = 0; s < n; s++)
      while (read_total[s] < sent_total[s])
        read_byte(test, s);
  endtask

  // Chip select monitor
  always @(negedge clk)
  begin
    if (n_rst)
      assert ((cs_low & (cs_low - 1'b1)) == '0)
      else abort_run("More than one chip select was low at the same time");
    for (int k = 0; k < n; k++)
    begin
      if (cs_prev[k] === 1'b1 && !n_cs_bus[k])
      begin
        cs_falls[k]++;
        cs_order.push_back(k);
      end
    end
    cs_prev = n_cs_bus;
  end

  initial
  begin
    #(watchdog_time);
    abort_run("Watchdog timeout, the transfers did not finish in time");
  end

  initial
  begin
    int falls_before [n];
    int first;
    int base;
    int rs;
    logic [n-1:0] seen;
    int unsigned r;
    clk = 1'b0;
    n_rst = 1'b0;
    m_din = '0;
    m_wrreq_bus = '0;
    s_rdreq_bus = '0;
    lcg_state = 45;
    for (int k = 0; k < n; k++)
      last_sent[k] = '0;
    repeat (8) @(negedge clk);

    check_value("reset n_cs_bus", (1 << n) - 1, n_cs_bus);
    check_value("reset sclk", spi_multi_pkg::cpol, sclk);
    check_levels("reset");
    n_rst = 1'b1;
    @(negedge clk);

    falls_before = cs_falls;
    push_byte(1, rand_byte());
    wait_done();
    check_logs("single");
    for (int k = 0; k < n; k++)
      check_value("single cs falls", k == 1, cs_falls[k] - falls_before[k]);
    check_levels("single");
    read_byte("single", 1);

    falls_before = cs_falls;
    repeat (5) push_byte(2, rand_byte());
    wait_done();
    check_value("burst cs falls", 1, cs_falls[2] - falls_before[2]);
    check_logs("burst");
    check_levels("burst");
    drain_all("burst");

    first = cs_order.size();
    for (int i = 0; i < 3; i++)
      for (int k = 0; k < n; k++)
        push_byte(k, rand_byte());
    wait_done();
    check_logs("round robin");
    check_levels("round robin");
    check_value("round robin bursts", n, cs_order.size() - first);
    seen = '0;
    for (int i = first; i < cs_order.size(); i++)
      seen[cs_order[i]] = 1'b1;
    check_value("round robin order", (1 << n) - 1, seen);
    drain_all("round robin");

    // Receive FIFO 0 fills and the last six bytes must wait
    base = log_size(0);
    for (int i = 0; i < 70; i++)
    begin
      while (sent_total[0] - log_size(0) >= spi_multi_pkg::fifo_depth)
        @(negedge clk);
      push_byte(0, rand_byte());
    end
    while (len_bus[0] != spi_multi_pkg::fifo_depth)
      @(negedge clk);
    repeat (3 * byte_cycles) @(negedge clk);
    check_value("backpressure len", spi_multi_pkg::fifo_depth, len_bus[0]);
    check_value("backpressure stall", spi_multi_pkg::fifo_depth, log_size(0) - base);
    check_value("backpressure n_cs_bus", (1 << n) - 1, n_cs_bus);
    repeat (spi_multi_pkg::fifo_depth) read_byte("backpressure", 0);
    wait_done();
    check_logs("backpressure");
    check_levels("backpressure");
    drain_all("backpressure");

    for (int i = 0; i < random_ops; i++)
    begin
      rs = rand_byte() % n;
      push_byte(rs, rand_byte());
      r = rand_byte();
      rs = (r >> 1) % n;
      if (r[0] && have_msg_bus[rs])
        read_byte("random", rs);
      repeat ((r >> 4) % 8) @(negedge clk);
    end
    wait_done();
    check_levels("random");
    check_logs("random");
    drain_all("random");
    check_levels("random drained");

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
